//--- bru_resolve/bru_resolve.sv
// execute stage: registers the head op and resolves target, taken, start pc and write data
`default_nettype none
`timescale 1ns/10ps

module bru_resolve (
    input  wire logic                         CLK,
    input  wire logic                         nRST,
    input  wire logic                         head_valid,
    input  wire bru_pkg::bru_issue_t          head,
    input  wire logic [bru_pkg::XLEN-1:0]     imm32,
    output logic                              take,
    input  wire logic                         wb_stall,
    output logic                              res_valid,
    output bru_pkg::bru_result_t              res
);

    logic             ex_valid;
    bru_pkg::bru_ex_t ex_q;
    logic             ex_stall;

    logic [bru_pkg::XLEN-1:0] pc_plus_imm;
    logic [bru_pkg::XLEN-1:0] pc_plus_2;
    logic [bru_pkg::XLEN-1:0] pc_plus_4;
    logic [bru_pkg::XLEN-1:0] a_plus_imm;
    logic a_eq_b;
    logic a_eq_zero;
    logic a_lts_b;
    logic a_ltu_b;
    logic br_cond;

    // only stall when there is something here to hold
    assign ex_stall = ex_valid & wb_stall;
    assign take     = head_valid & ~ex_stall;

    // ------------------------------
    // EX register

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ex_valid <= 1'b0;
        end else if (!ex_stall) begin
            ex_valid <= head_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            ex_q.op        <= head.op;
            ex_q.pc        <= head.pc;
            ex_q.pred_pc   <= head.pred_pc;
            ex_q.imm32     <= imm32;
            ex_q.a_data    <= head.a_data;
            ex_q.b_data    <= head.b_data;
            ex_q.dest_pr   <= head.dest_pr;
            ex_q.rob_index <= head.rob_index;
        end
    end

    // ------------------------------
    // adders and comparators

    assign pc_plus_imm = ex_q.pc + ex_q.imm32;
    assign pc_plus_2   = ex_q.pc + 32'd2;
    assign pc_plus_4   = ex_q.pc + 32'd4;
    assign a_plus_imm  = ex_q.a_data + ex_q.imm32;
    assign a_eq_b      = ex_q.a_data == ex_q.b_data;
    assign a_eq_zero   = ex_q.a_data == '0;
    assign a_lts_b     = $signed(ex_q.a_data) < $signed(ex_q.b_data);
    assign a_ltu_b     = ex_q.a_data < ex_q.b_data;

    // branch condition per opcode
    always_comb begin
        case (ex_q.op)
            bru_pkg::BEQ:    br_cond = a_eq_b;
            bru_pkg::BNE:    br_cond = ~a_eq_b;
            bru_pkg::C_BEQZ: br_cond = a_eq_zero;
            bru_pkg::C_BNEZ: br_cond = ~a_eq_zero;
            bru_pkg::BLT:    br_cond = a_lts_b;
            bru_pkg::BGE:    br_cond = ~a_lts_b;
            bru_pkg::BLTU:   br_cond = a_ltu_b;
            bru_pkg::BGEU:   br_cond = ~a_ltu_b;
            default:         br_cond = 1'b0;
        endcase
    end

    // ------------------------------
    // per-op resolution

    always_comb begin
        res.op        = ex_q.op;
        res.pred_pc   = ex_q.pred_pc;
        res.dest_pr   = ex_q.dest_pr;
        res.rob_index = ex_q.rob_index;

        // 32-bit forms as the baseline
        res.is_taken   = 1'b1;
        res.target_pc  = pc_plus_imm;
        res.start_pc   = pc_plus_2;
        res.write_data = pc_plus_4;

        case (ex_q.op)
            bru_pkg::JALR:   res.target_pc = a_plus_imm;
            bru_pkg::JAL:    ;  // baseline already fits
            bru_pkg::C_JALR: begin
                res.target_pc  = ex_q.a_data;
                res.start_pc   = ex_q.pc;
                res.write_data = pc_plus_2;
            end
            bru_pkg::C_JAL: begin
                res.start_pc   = ex_q.pc;
                res.write_data = pc_plus_2;
            end
            bru_pkg::C_J:    res.start_pc = ex_q.pc;
            bru_pkg::C_JR: begin
                res.target_pc = ex_q.a_data;
                res.start_pc  = ex_q.pc;
            end
            bru_pkg::LUI: begin
                res.is_taken   = 1'b0;
                res.write_data = ex_q.imm32;
            end
            bru_pkg::AUIPC: begin
                res.is_taken   = 1'b0;
                res.write_data = pc_plus_imm;
            end
            bru_pkg::C_BEQZ,
            bru_pkg::C_BNEZ: begin
                res.is_taken  = br_cond;
                res.target_pc = br_cond ? pc_plus_imm : pc_plus_2;
                res.start_pc  = ex_q.pc;   // 16-bit fall-through
            end
            default: begin
                res.is_taken  = br_cond;
                res.target_pc = br_cond ? pc_plus_imm : pc_plus_4;
            end
        endcase
    end

    assign res_valid = ex_valid;

endmodule

`default_nettype wire

//--- build.f
+incdir+dv
common/bru_pkg.sv
rtl/bru_issue_buffer.sv
rtl/bru_imm_expand.sv
bru_resolve/bru_resolve.sv
rtl/bru_writeback.sv
rtl/bru_pipeline.sv
dv/bru_tb.sv

//--- common/bru_pkg.sv
// shared widths, opcode enum and stage payload structs for the branch resolution unit
`default_nettype none

package bru_pkg;

    // ------------------------------
    // widths and sizes

    localparam int XLEN        = 32;
    localparam int IMM20_WIDTH = 20;
    localparam int PR_W        = 7;  // physical register tag
    localparam int ROB_W       = 7;  // reorder buffer index
    localparam int ISSUE_DEPTH = 2;
    localparam int ISSUE_PTR_W = $clog2(ISSUE_DEPTH);
    localparam int ISSUE_CNT_W = $clog2(ISSUE_DEPTH + 1);

    // ------------------------------
    // opcodes

    // bit 3 set marks a conditional branch
    typedef enum logic [3:0] {
        JALR   = 4'd0,
        C_JALR = 4'd1,
        JAL    = 4'd2,
        C_JAL  = 4'd3,
        C_J    = 4'd4,
        C_JR   = 4'd5,
        LUI    = 4'd6,
        AUIPC  = 4'd7,
        BEQ    = 4'd8,
        BNE    = 4'd9,
        C_BEQZ = 4'd10,
        C_BNEZ = 4'd11,
        BLT    = 4'd12,
        BGE    = 4'd13,
        BLTU   = 4'd14,
        BGEU   = 4'd15
    } bru_op_e;

    // ------------------------------
    // stage payloads

    typedef struct packed {
        bru_op_e                op;
        logic [XLEN-1:0]        pc;
        logic [XLEN-1:0]        pred_pc;
        logic [IMM20_WIDTH-1:0] imm20;      // packed immediate, sign at bit 11
        logic [XLEN-1:0]        a_data;
        logic [XLEN-1:0]        b_data;
        logic [PR_W-1:0]        dest_pr;
        logic [ROB_W-1:0]       rob_index;
    } bru_issue_t;

    typedef struct packed {
        bru_op_e          op;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  pred_pc;
        logic [XLEN-1:0]  imm32;
        logic [XLEN-1:0]  a_data;
        logic [XLEN-1:0]  b_data;
        logic [PR_W-1:0]  dest_pr;
        logic [ROB_W-1:0] rob_index;
    } bru_ex_t;

    typedef struct packed {
        bru_op_e          op;
        logic             is_taken;
        logic [XLEN-1:0]  start_pc;
        logic [XLEN-1:0]  target_pc;
        logic [XLEN-1:0]  pred_pc;
        logic [XLEN-1:0]  write_data;
        logic [PR_W-1:0]  dest_pr;
        logic [ROB_W-1:0] rob_index;
    } bru_result_t;

    // register writeback to the PRF
    typedef struct packed {
        logic [XLEN-1:0]  data;
        logic [PR_W-1:0]  pr;
        logic [ROB_W-1:0] rob_index;
    } bru_wb_t;

    // branch notification to the ROB
    typedef struct packed {
        logic [ROB_W-1:0] rob_index;
        logic             is_mispredict;
        logic             is_taken;
        logic [XLEN-1:0]  start_pc;
        logic [XLEN-1:0]  target_pc;
    } bru_notif_t;

endpackage

`default_nettype wire

//--- dv/bru_tb_model.svh
// reference model for the testbench, included inside bru_tb to predict outputs per issued op
`ifndef BRU_TB_MODEL_SVH
`define BRU_TB_MODEL_SVH

// 32-bit immediate from the packed form, sign always at bit 11
function automatic logic [31:0] expand_imm(input bru_pkg::bru_op_e op, input logic [19:0] i20);
    logic s;
    s = i20[11];
    if (op == bru_pkg::LUI || op == bru_pkg::AUIPC)
        return {s, i20[10:0], i20[19:12], 12'h000};
    else if (op == bru_pkg::JALR)
        return {{20{s}}, i20[11:0]};
    else if (op >= bru_pkg::BEQ)
        return {{20{s}}, i20[0], i20[10:1], 1'b0};   // branch offset
    else
        return {{12{s}}, i20[19:12], i20[0], i20[10:1], 1'b0};
endfunction

function automatic logic branch_taken(input bru_pkg::bru_op_e op, input logic [31:0] a,
                                      input logic [31:0] b);
    logic slt;
    slt = (a[31] != b[31]) ? a[31] : (a < b);   // signed compare by sign bits first
    case (op)
        bru_pkg::BEQ:    return a == b;
        bru_pkg::BNE:    return a != b;
        bru_pkg::C_BEQZ: return a == 32'd0;
        bru_pkg::C_BNEZ: return a != 32'd0;
        bru_pkg::BLT:    return slt;
        bru_pkg::BGE:    return !slt;
        bru_pkg::BLTU:   return a < b;
        bru_pkg::BGEU:   return a >= b;
        default:         return 1'b1;           // jumps always taken
    endcase
endfunction

function automatic exp_t model_result(input bru_pkg::bru_issue_t t, input logic [31:0] acc_edge);
    exp_t        e;
    logic [31:0] imm;
    logic [31:0] tgt;
    logic [31:0] start;
    logic [31:0] data;
    logic        taken;
    imm   = expand_imm(t.op, t.imm20);
    taken = branch_taken(t.op, t.a_data, t.b_data);
    tgt   = t.pc + imm;
    start = t.pc;
    data  = 32'd0;
    case (t.op)
        bru_pkg::JALR: begin
            tgt   = t.a_data + imm;
            start = t.pc + 32'd2;
            data  = t.pc + 32'd4;
        end
        bru_pkg::C_JALR: begin
            tgt  = t.a_data;
            data = t.pc + 32'd2;
        end
        bru_pkg::JAL: begin
            start = t.pc + 32'd2;
            data  = t.pc + 32'd4;
        end
        bru_pkg::C_JAL:  data = t.pc + 32'd2;
        bru_pkg::C_J:    tgt = t.pc + imm;
        bru_pkg::C_JR:   tgt = t.a_data;
        bru_pkg::LUI:    data = imm;
        bru_pkg::AUIPC:  data = t.pc + imm;
        bru_pkg::C_BEQZ,
        bru_pkg::C_BNEZ: tgt = taken ? t.pc + imm : t.pc + 32'd2;
        default: begin                          // 32-bit branches
            tgt   = taken ? t.pc + imm : t.pc + 32'd4;
            start = t.pc + 32'd2;
        end
    endcase
    e.has_wb = t.op inside {bru_pkg::JALR, bru_pkg::C_JALR, bru_pkg::JAL, bru_pkg::C_JAL,
                            bru_pkg::LUI, bru_pkg::AUIPC};
    e.has_notif           = !(t.op inside {bru_pkg::LUI, bru_pkg::AUIPC});
    e.wb.data             = data;
    e.wb.pr               = t.dest_pr;
    e.wb.rob_index        = t.rob_index;
    e.notif.rob_index     = t.rob_index;
    e.notif.is_mispredict = tgt != t.pred_pc;
    e.notif.is_taken      = taken;
    e.notif.start_pc      = start;
    e.notif.target_pc     = tgt;
    e.accept_edge         = acc_edge;
    return e;
endfunction

`endif

//--- dv/bru_tb.sv
// testbench for the branch resolution unit: directed tests, reference model and output monitor
`default_nettype none
`timescale 1ns/10ps

module bru_tb;

    localparam int TIMEOUT = 200;   // cycles allowed per wait

    typedef struct packed {
        logic                has_wb;
        bru_pkg::bru_wb_t    wb;
        logic                has_notif;
        bru_pkg::bru_notif_t notif;
        logic [31:0]         accept_edge;
    } exp_t;

    logic                CLK;
    logic                nRST;
    logic                issue_valid;
    bru_pkg::bru_issue_t issue;
    logic                issue_ready;
    logic                wb_valid;
    bru_pkg::bru_wb_t    wb;
    logic                wb_ready;
    logic                notif_valid;
    bru_pkg::bru_notif_t notif;
    logic                notif_ready;

    exp_t        expq [$];          // outstanding ops in issue order
    exp_t        mon_exp;
    int          errors = 0;
    logic [31:0] edge_count = 32'd0;
    logic [31:0] rng = 32'hfd1b;
    logic        check_latency = 1'b0;

    `include "bru_tb_model.svh"

    bru_pipeline bru_pipeline_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .wb_ready    (wb_ready),
        .notif_valid (notif_valid),
        .notif       (notif),
        .notif_ready (notif_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // ------------------------------
    // helpers

    function logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic bru_pkg::bru_op_e random_op();
        logic [31:0] r;
        r = rand32();
        return bru_pkg::bru_op_e'(r[3:0]);
    endfunction

    function automatic bru_pkg::bru_issue_t rand_issue(input bru_pkg::bru_op_e op);
        bru_pkg::bru_issue_t t;
        t.op        = op;
        t.pc        = rand32() & ~32'd1;    // halfword aligned
        t.pred_pc   = rand32() & ~32'd1;
        t.imm20     = 20'(rand32());
        t.a_data    = rand32();
        t.b_data    = rand32();
        t.dest_pr   = 7'(rand32());
        t.rob_index = 7'(rand32());
        return t;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // called at a falling edge, returns at the falling edge after acceptance
    task automatic issue_op(input bru_pkg::bru_issue_t op_in);
        int waited;
        waited      = 0;
        issue_valid = 1'b1;
        issue       = op_in;
        while (!issue_ready && waited < TIMEOUT) begin
            @(negedge CLK);
            waited++;
        end
        if (!issue_ready) begin
            errors++;
            $display("issue_ready stayed low for %0d cycles, operation never accepted", TIMEOUT);
        end else begin
            expq.push_back(model_result(op_in, edge_count + 32'd1));
            @(negedge CLK);
        end
        issue_valid = 1'b0;
    endtask

    task automatic drain(input logic random_ready);
        int          waited;
        logic [31:0] r;
        waited = 0;
        while (expq.size() != 0 && waited < TIMEOUT) begin
            if (random_ready) begin
                r           = rand32();
                wb_ready    = r[0];
                notif_ready = r[1];
            end
            @(negedge CLK);
            waited++;
        end
        wb_ready    = 1'b1;
        notif_ready = 1'b1;
        if (expq.size() != 0) begin
            errors++;
            $display("%0d expected outputs never appeared", expq.size());
            expq.delete();
        end
        repeat (2) @(negedge CLK);  // room for stray outputs
    endtask

    // ------------------------------
    // output monitor

    always @(posedge CLK) begin
        edge_count = edge_count + 32'd1;
        if (wb_valid || notif_valid) begin
            if (expq.size() == 0) begin
                errors++;
                $display("output at time %0t with no operation outstanding", $time);
            end else begin
                mon_exp = expq.pop_front();
                check(32'(wb_valid), 32'(mon_exp.has_wb), "wb_valid");
                check(32'(notif_valid), 32'(mon_exp.has_notif), "notif_valid");
                if (mon_exp.has_wb) begin
                    check(wb.data, mon_exp.wb.data, "wb data");
                    check(32'(wb.pr), 32'(mon_exp.wb.pr), "wb pr");
                    check(32'(wb.rob_index), 32'(mon_exp.wb.rob_index), "wb rob_index");
                end
                if (mon_exp.has_notif) begin
                    check(32'(notif.rob_index), 32'(mon_exp.notif.rob_index), "notif rob_index");
                    check(32'(notif.is_mispredict), 32'(mon_exp.notif.is_mispredict),
                          "notif mispredict");
                    check(32'(notif.is_taken), 32'(mon_exp.notif.is_taken), "notif taken");
                    check(notif.start_pc, mon_exp.notif.start_pc, "notif start_pc");
                    check(notif.target_pc, mon_exp.notif.target_pc, "notif target_pc");
                end
                if (check_latency)
                    check(edge_count - mon_exp.accept_edge, 32'd3, "issue to output edges");
            end
        end
    end

    // ------------------------------
    // directed tests

    task automatic after_reset();
        check(32'(wb_valid), 32'd0, "wb_valid after reset");
        check(32'(notif_valid), 32'd0, "notif_valid after reset");
        check(32'(issue_ready), 32'd1, "issue_ready after reset");
    endtask

    task automatic jump_ops();
        bru_pkg::bru_op_e    ops [6];
        bru_pkg::bru_issue_t t;
        exp_t                e;
        ops = '{bru_pkg::JALR, bru_pkg::C_JALR, bru_pkg::JAL,
                bru_pkg::C_JAL, bru_pkg::C_J, bru_pkg::C_JR};
        for (int i = 0; i < 12; i++) begin
            t = rand_issue(ops[i % 6]);
            if (i >= 6) begin   // second round predicted right
                e         = model_result(t, 32'd0);
                t.pred_pc = e.notif.target_pc;
            end
            issue_op(t);
        end
        drain(1'b0);
    endtask

    task automatic branch_ops();
        logic [31:0]         pa [6];
        logic [31:0]         pb [6];
        bru_pkg::bru_op_e    ops [8];
        bru_pkg::bru_issue_t t;
        // equal, sign differs both ways, unsigned wrap both ways, zero
        pa  = '{32'd5, 32'h8000_0000, 32'd1, 32'hffff_ffff, 32'd0, 32'd0};
        pb  = '{32'd5, 32'd1, 32'h8000_0000, 32'd0, 32'hffff_ffff, 32'd0};
        ops = '{bru_pkg::BEQ, bru_pkg::BNE, bru_pkg::C_BEQZ, bru_pkg::C_BNEZ,
                bru_pkg::BLT, bru_pkg::BGE, bru_pkg::BLTU, bru_pkg::BGEU};
        foreach (ops[i]) begin
            foreach (pa[j]) begin
                t        = rand_issue(ops[i]);
                t.a_data = pa[j];
                t.b_data = pb[j];
                issue_op(t);
            end
        end
        drain(1'b0);
    endtask

    task automatic upper_imm_ops();
        for (int i = 0; i < 8; i++) begin
            issue_op(rand_issue((i % 2 == 0) ? bru_pkg::LUI : bru_pkg::AUIPC));
        end
        drain(1'b0);
    endtask

    task automatic back_pressure();
        repeat (3) begin
            wb_ready    = 1'b0;
            notif_ready = 1'b0;
            repeat (4) issue_op(rand_issue(random_op()));   // WB, EX and both buffer slots
            check(32'(issue_ready), 32'd0, "issue_ready with full pipeline");
            repeat (3) @(negedge CLK);
            drain(1'b1);
        end
    endtask

    task automatic throughput();
        check_latency = 1'b1;
        repeat (8) issue_op(rand_issue(random_op()));
        drain(1'b0);
        check_latency = 1'b0;
    endtask

    initial begin
        nRST        = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        wb_ready    = 1'b1;
        notif_ready = 1'b1;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        after_reset();
        jump_ops();
        branch_ops();
        upper_imm_ops();
        back_pressure();
        throughput();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/bru_imm_expand.sv
// expands the packed 20-bit immediate of an issued op into its 32-bit form
`default_nettype none
`timescale 1ns/10ps

module bru_imm_expand (
    input  wire bru_pkg::bru_op_e                op,
    input  wire logic [bru_pkg::IMM20_WIDTH-1:0] imm20,
    output logic [bru_pkg::XLEN-1:0]             imm32
);

    logic sign;

    // the sign always sits at imm20[11]
    assign sign = imm20[11];

    always_comb begin
        imm32[31] = sign;

        case (op)
            // ------------------------------
            // U-type
            bru_pkg::LUI,
            bru_pkg::AUIPC: begin
                imm32[30:20] = imm20[10:0];
                imm32[19:12] = imm20[19:12];
                imm32[11:0]  = 12'h000;
            end

            // ------------------------------
            // I-type
            bru_pkg::JALR: begin
                imm32[30:20] = {11{sign}};
                imm32[19:12] = {8{sign}};
                imm32[11:0]  = imm20[11:0];
            end

            // ------------------------------
            // J-type, remaining jumps
            bru_pkg::C_JALR,
            bru_pkg::JAL,
            bru_pkg::C_JAL,
            bru_pkg::C_J,
            bru_pkg::C_JR: begin
                imm32[30:20] = {11{sign}};
                imm32[19:12] = imm20[19:12];
                imm32[11]    = imm20[0];
                imm32[10:1]  = imm20[10:1];
                imm32[0]     = 1'b0;
            end

            // ------------------------------
            // B-type, every conditional branch
            default: begin
                imm32[30:20] = {11{sign}};
                imm32[19:12] = {8{sign}};
                imm32[11]    = imm20[0];     // B-imm bit 11 parked in bit 0
                imm32[10:1]  = imm20[10:1];
                imm32[0]     = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/bru_issue_buffer.sv
// two-entry fall-through buffer between the issue queue and the execute stage
`default_nettype none
`timescale 1ns/10ps

module bru_issue_buffer (
    input  wire logic                CLK,
    input  wire logic                nRST,
    input  wire logic                issue_valid,
    input  wire bru_pkg::bru_issue_t issue,
    output logic                     issue_ready,
    output logic                     head_valid,
    output bru_pkg::bru_issue_t      head,
    input  wire logic                take
);

    bru_pkg::bru_issue_t entries [bru_pkg::ISSUE_DEPTH];

    logic [bru_pkg::ISSUE_PTR_W-1:0] wr_ptr;
    logic [bru_pkg::ISSUE_PTR_W-1:0] rd_ptr;
    logic [bru_pkg::ISSUE_CNT_W-1:0] count;

    logic push;
    logic pop;

    assign issue_ready = count != bru_pkg::ISSUE_CNT_W'(bru_pkg::ISSUE_DEPTH);
    assign head_valid  = count != '0;
    assign head        = entries[rd_ptr];   // fall-through from read pointer

    assign push = issue_valid & issue_ready;
    assign pop  = take & head_valid;

    // ------------------------------
    // pointers and occupancy

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == bru_pkg::ISSUE_PTR_W'(bru_pkg::ISSUE_DEPTH - 1))
                    wr_ptr <= '0;
                else
                    wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                if (rd_ptr == bru_pkg::ISSUE_PTR_W'(bru_pkg::ISSUE_DEPTH - 1))
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // idle, or push and pop together
            endcase
        end
    end

    // storage
    always_ff @(posedge CLK) begin
        if (push) begin
            entries[wr_ptr] <= issue;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bru_pipeline.sv
// branch resolution unit top: issue buffer, immediate expand, execute and writeback stages
`default_nettype none
`timescale 1ns/10ps

module bru_pipeline (
    input  wire logic                 CLK,
    input  wire logic                 nRST,

    // issue from the BRU issue queue
    input  wire logic                 issue_valid,
    input  wire bru_pkg::bru_issue_t  issue,
    output logic                      issue_ready,

    // register writeback to the PRF
    output logic                      wb_valid,
    output bru_pkg::bru_wb_t          wb,
    input  wire logic                 wb_ready,

    // branch notification to the ROB
    output logic                      notif_valid,
    output bru_pkg::bru_notif_t       notif,
    input  wire logic                 notif_ready
);

    // ------------------------------
    // internal paths

    logic                     head_valid;
    bru_pkg::bru_issue_t      head;
    logic [bru_pkg::XLEN-1:0] imm32;
    logic                     take;
    logic                     res_valid;
    bru_pkg::bru_result_t     res;
    logic                     wb_stall;

    bru_issue_buffer buffer_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .head_valid  (head_valid),
        .head        (head),
        .take        (take)
    );

    // immediate is formed ahead of the EX register
    bru_imm_expand imm_expand_i (
        .op    (head.op),
        .imm20 (head.imm20),
        .imm32 (imm32)
    );

    bru_resolve resolve_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .head_valid (head_valid),
        .head       (head),
        .imm32      (imm32),
        .take       (take),
        .wb_stall   (wb_stall),
        .res_valid  (res_valid),
        .res        (res)
    );

    bru_writeback writeback_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .res_valid   (res_valid),
        .res         (res),
        .wb_stall    (wb_stall),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .wb_ready    (wb_ready),
        .notif_valid (notif_valid),
        .notif       (notif),
        .notif_ready (notif_ready)
    );

endmodule

`default_nettype wire

//--- rtl/bru_writeback.sv
// writeback stage: holds the resolved op and drives the PRF writeback and ROB notification
`default_nettype none
`timescale 1ns/10ps

module bru_writeback (
    input  wire logic                 CLK,
    input  wire logic                 nRST,
    input  wire logic                 res_valid,
    input  wire bru_pkg::bru_result_t res,
    output logic                      wb_stall,
    output logic                      wb_valid,
    output bru_pkg::bru_wb_t          wb,
    input  wire logic                 wb_ready,
    output logic                      notif_valid,
    output bru_pkg::bru_notif_t       notif,
    input  wire logic                 notif_ready
);

    logic                 wb_stage_valid;
    bru_pkg::bru_result_t wb_q;

    logic need_wb;
    logic need_notif;

    // ------------------------------
    // WB register

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wb_stage_valid <= 1'b0;
        end else if (!wb_stall) begin
            wb_stage_valid <= res_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!wb_stall) begin
            wb_q <= res;
        end
    end

    // ------------------------------
    // output needs per opcode

    always_comb begin
        case (wb_q.op)
            bru_pkg::JALR,
            bru_pkg::C_JALR,
            bru_pkg::JAL,
            bru_pkg::C_JAL: begin   // linking jumps need both
                need_wb    = wb_stage_valid;
                need_notif = wb_stage_valid;
            end
            bru_pkg::LUI,
            bru_pkg::AUIPC: begin
                need_wb    = wb_stage_valid;
                need_notif = 1'b0;
            end
            default: begin          // C.J, C.JR and branches
                need_wb    = 1'b0;
                need_notif = wb_stage_valid;
            end
        endcase
    end

    // any required consumer not ready holds the whole stage
    assign wb_stall = (need_wb & ~wb_ready) | (need_notif & ~notif_ready);

    // both outputs go out together or not at all
    assign wb_valid    = need_wb & ~wb_stall;
    assign notif_valid = need_notif & ~wb_stall;

    // ------------------------------
    // payloads

    assign wb.data      = wb_q.write_data;
    assign wb.pr        = wb_q.dest_pr;
    assign wb.rob_index = wb_q.rob_index;

    assign notif.rob_index     = wb_q.rob_index;
    assign notif.is_mispredict = wb_q.target_pc != wb_q.pred_pc;
    assign notif.is_taken      = wb_q.is_taken;
    assign notif.start_pc      = wb_q.start_pc;
    assign notif.target_pc     = wb_q.target_pc;

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds the branch resolution unit testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f build.f \
    --top-module bru_tb \
    -Mdir obj_dir \
    -o bru_tb_sim

./obj_dir/bru_tb_sim > sim.log
cat sim.log

if grep -qF "** PASS **" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
